// ==== design/name_pkg.sv ====
package name_pkg;

   //////////////////////////////////////////////////
   // Widths
   //////////////////////////////////////////////////

   // Screen coordinate
   localparam int pix_w = 12;

   // One ASCII code from the processing system
   localparam int char_w = 8;

   // Glyph index, row number and column number
   localparam int glyph_idx_w = 5;
   localparam int row_w = 4;
   localparam int col_w = 2;

   //////////////////////////////////////////////////
   // Font
   //////////////////////////////////////////////////

   // Valid letters are A to Z only
   localparam int ascii_a = 65;
   localparam int ascii_z = 90;

   // Glyph cell, 3 columns by 12 rows
   localparam int glyph_w = 3;
   localparam int glyph_h = 12;

   // 26 letters plus the question mark
   localparam int glyph_count = 27;
   localparam int unknown_glyph = 26;

   //////////////////////////////////////////////////
   // Placement on the game-over screen
   //////////////////////////////////////////////////

   localparam int num_letters = 3;

   // Left column of the first letter
   localparam int name_x0 = 300;

   // Column distance from one letter to the next
   localparam int letter_pitch = 30;

   // Top row shared by all letters
   localparam int name_y = 170;

   // Overlay colour, yellow
   localparam logic [23:0] name_rgb = 24'hFFFF00;

endpackage

// ==== design/glyph_rom.sv ====
`timescale 1ns/1ps

module glyph_rom
   import name_pkg::*;
(
   input  logic [glyph_idx_w-1:0] glyph,
   input  logic [row_w-1:0]       row,
   output logic [glyph_w-1:0]     pattern
);

   // All 12 rows of one glyph with row 0 in the top bits
   logic [glyph_w*glyph_h-1:0] glyph_bits;
   logic [row_w-1:0]           flip;

   //////////////////////////////////////////////////
   // Font table with the leftmost pixel as MSB
   //////////////////////////////////////////////////

   always_comb begin
      case (glyph)
         // A to G
         5'd0:  glyph_bits = 36'b111_101_101_101_101_101_111_101_101_101_101_101;
         5'd1:  glyph_bits = 36'b111_111_101_101_101_101_111_101_101_101_101_111;
         5'd2:  glyph_bits = 36'b111_100_100_100_100_100_100_100_100_100_100_111;
         5'd3:  glyph_bits = 36'b110_101_101_101_101_101_101_101_101_101_101_110;
         5'd4:  glyph_bits = 36'b111_100_100_100_100_100_111_100_100_100_100_111;
         5'd5:  glyph_bits = 36'b111_100_100_100_100_100_111_100_100_100_100_100;
         5'd6:  glyph_bits = 36'b111_100_100_100_100_100_101_101_101_101_101_111;
         // H to N
         5'd7:  glyph_bits = 36'b101_101_101_101_101_101_111_101_101_101_101_101;
         5'd8:  glyph_bits = 36'b111_010_010_010_010_010_010_010_010_010_010_111;
         5'd9:  glyph_bits = 36'b001_001_001_001_001_001_001_001_001_001_101_111;
         5'd10: glyph_bits = 36'b101_101_101_101_101_101_110_101_101_101_101_101;
         5'd11: glyph_bits = 36'b100_100_100_100_100_100_100_100_100_100_100_111;
         5'd12: glyph_bits = 36'b101_111_111_111_111_101_101_101_101_101_101_101;
         5'd13: glyph_bits = 36'b110_101_101_101_101_101_101_101_101_101_101_101;
         // O to U
         5'd14: glyph_bits = 36'b111_101_101_101_101_101_101_101_101_101_101_111;
         5'd15: glyph_bits = 36'b111_101_101_101_101_101_111_100_100_100_100_100;
         5'd16: glyph_bits = 36'b111_101_101_101_101_101_101_101_101_101_111_001;
         5'd17: glyph_bits = 36'b111_101_101_101_101_101_110_101_101_101_101_101;
         5'd18: glyph_bits = 36'b111_100_100_100_100_100_111_001_001_001_001_111;
         5'd19: glyph_bits = 36'b111_010_010_010_010_010_010_010_010_010_010_010;
         5'd20: glyph_bits = 36'b101_101_101_101_101_101_101_101_101_101_101_111;
         // V to Z
         5'd21: glyph_bits = 36'b101_101_101_101_101_101_101_101_101_101_101_010;
         5'd22: glyph_bits = 36'b101_101_101_101_101_101_101_111_111_111_111_101;
         5'd23: glyph_bits = 36'b101_101_101_101_101_101_010_101_101_101_101_101;
         5'd24: glyph_bits = 36'b101_101_101_101_101_101_101_010_010_010_010_010;
         5'd25: glyph_bits = 36'b111_001_001_001_001_001_010_100_100_100_100_111;
         // Question mark and anything past the table
         default: begin
            glyph_bits = 36'b010_101_001_001_001_010_010_000_010_010_000_010;
         end
      endcase
   end

   //////////////////////////////////////////////////
   // Row select
   //////////////////////////////////////////////////

   // Row 0 sits in the top group of bits
   assign flip = row_w'(glyph_h - 1) - row;

   always_comb begin
      pattern = '0;
      if (row < row_w'(glyph_h)) begin
         pattern = glyph_bits[flip * glyph_w +: glyph_w];
      end
   end

endmodule

// ==== design/char_decode.sv ====
`timescale 1ns/1ps

module char_decode
   import name_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic [char_w-1:0]      p_c0,
   input  logic [char_w-1:0]      p_c1,
   input  logic [char_w-1:0]      p_c2,
   output logic [glyph_idx_w-1:0] glyph_idx0,
   output logic [glyph_idx_w-1:0] glyph_idx1,
   output logic [glyph_idx_w-1:0] glyph_idx2
);

   // Capital letter to font index, anything else to the question mark
   function automatic logic [glyph_idx_w-1:0] to_glyph(input logic [char_w-1:0] code);
      if (code >= char_w'(ascii_a) && code <= char_w'(ascii_z)) begin
         return glyph_idx_w'(code - char_w'(ascii_a));
      end
      return glyph_idx_w'(unknown_glyph);
   endfunction

   // Codes change rarely, one clock of delay is harmless
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         glyph_idx0 <= glyph_idx_w'(unknown_glyph);
         glyph_idx1 <= glyph_idx_w'(unknown_glyph);
         glyph_idx2 <= glyph_idx_w'(unknown_glyph);
      end else begin
         glyph_idx0 <= to_glyph(p_c0);
         glyph_idx1 <= to_glyph(p_c1);
         glyph_idx2 <= to_glyph(p_c2);
      end
   end

endmodule

// ==== design/letter_slot.sv ====
`timescale 1ns/1ps

module letter_slot
   import name_pkg::*;
#(
   parameter int slot_x = name_x0
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic [pix_w-1:0]       pix_x,
   input  logic [pix_w-1:0]       pix_y,
   input  logic [glyph_idx_w-1:0] glyph_idx,
   output logic                   lit
);

   logic [pix_w-1:0]       dx;
   logic [pix_w-1:0]       dy;
   logic                   in_box;
   logic                   hit_q;
   logic [row_w-1:0]       row_q;
   logic [col_w-1:0]       col_q;
   logic [glyph_idx_w-1:0] glyph_q;
   logic [glyph_w-1:0]     pattern;
   logic [col_w-1:0]       bit_sel;
   logic                   col_bit;

   //////////////////////////////////////////////////
   // Stage 1, bounding box and offsets
   //////////////////////////////////////////////////

   // Offsets wrap when the pixel is left of or above the box
   assign dx = pix_x - pix_w'(slot_x);
   assign dy = pix_y - pix_w'(name_y);

   assign in_box = (pix_x >= pix_w'(slot_x)) && (dx < pix_w'(glyph_w)) &&
                   (pix_y >= pix_w'(name_y)) && (dy < pix_w'(glyph_h));

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         hit_q <= 1'b0;
      end else begin
         hit_q <= in_box;
      end
   end

   always_ff @(posedge clk) begin
      row_q   <= row_w'(dy);
      col_q   <= col_w'(dx);
      glyph_q <= glyph_idx;
   end

   //////////////////////////////////////////////////
   // Stage 2, font lookup
   //////////////////////////////////////////////////

   glyph_rom i_glyph_rom (
      .glyph   (glyph_q),
      .row     (row_q),
      .pattern (pattern)
   );

   // Column 0 is the leftmost pixel, held in the MSB
   assign bit_sel = col_w'(glyph_w - 1) - col_q;
   assign col_bit = (col_q < col_w'(glyph_w)) ? pattern[bit_sel] : 1'b0;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         lit <= 1'b0;
      end else begin
         lit <= hit_q & col_bit;
      end
   end

endmodule

// ==== design/overlay_mixer.sv ====
`timescale 1ns/1ps

module overlay_mixer
   import name_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        lit0,
   input  logic        lit1,
   input  logic        lit2,
   output logic        na_l_on,
   output logic [23:0] na_l_rgb
);

   logic any_lit;

   // Letters never overlap, a plain OR is enough
   assign any_lit = lit0 | lit1 | lit2;

   // Black outside the letters so the screen mux can OR colours
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         na_l_on  <= 1'b0;
         na_l_rgb <= '0;
      end else begin
         na_l_on  <= any_lit;
         na_l_rgb <= any_lit ? name_rgb : '0;
      end
   end

endmodule

// ==== design/gameover_name.sv ====
`timescale 1ns/1ps

module gameover_name
   import name_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic [pix_w-1:0]  pix_x,
   input  logic [pix_w-1:0]  pix_y,
   input  logic [char_w-1:0] p_c0,
   input  logic [char_w-1:0] p_c1,
   input  logic [char_w-1:0] p_c2,
   output logic              na_l_on,
   output logic [23:0]       na_l_rgb
);

   logic [glyph_idx_w-1:0] glyph_idx [num_letters];
   logic [num_letters-1:0] lit;

   char_decode i_char_decode (
      .clk        (clk),
      .rst_n      (rst_n),
      .p_c0       (p_c0),
      .p_c1       (p_c1),
      .p_c2       (p_c2),
      .glyph_idx0 (glyph_idx[0]),
      .glyph_idx1 (glyph_idx[1]),
      .glyph_idx2 (glyph_idx[2])
   );

   // One slot per letter, spaced a fixed pitch apart
   for (genvar i = 0; i < num_letters; i++) begin : g_slot
      letter_slot #(
         .slot_x (name_x0 + i * letter_pitch)
      ) i_letter_slot (
         .clk       (clk),
         .rst_n     (rst_n),
         .pix_x     (pix_x),
         .pix_y     (pix_y),
         .glyph_idx (glyph_idx[i]),
         .lit       (lit[i])
      );
   end

   overlay_mixer i_overlay_mixer (
      .clk      (clk),
      .rst_n    (rst_n),
      .lit0     (lit[0]),
      .lit1     (lit[1]),
      .lit2     (lit[2]),
      .na_l_on  (na_l_on),
      .na_l_rgb (na_l_rgb)
   );

endmodule

// ==== testbench/tb_gameover_name.sv ====
`timescale 1ns/1ps

module tb_gameover_name
   import name_pkg::*;
();

   localparam int clk_period = 100;
   localparam int rand_count = 200;
   localparam int margin_cycles = 200;
   localparam int max_vectors = 128;

   logic              clk;
   logic              rst_n;
   logic [pix_w-1:0]  pix_x;
   logic [pix_w-1:0]  pix_y;
   logic [char_w-1:0] p_c0;
   logic [char_w-1:0] p_c1;
   logic [char_w-1:0] p_c2;
   logic              na_l_on;
   logic [23:0]       na_l_rgb;

   // Test id, three codes, pix_x, pix_y, expected enable
   logic [55:0] vectors [max_vectors];
   int          num_vec = 0;
   logic        limits_known = 1'b0;

   // Expected enables and the cycle each one is due
   logic exp_q [$];
   int   due_q [$];
   int   cycle = 0;
   int   error_count = 0;
   int   test_errors_start = 0;
   int   test_count = 0;
   int   failed_tests = 0;

   gameover_name i_gameover_name (
      .clk      (clk),
      .rst_n    (rst_n),
      .pix_x    (pix_x),
      .pix_y    (pix_y),
      .p_c0     (p_c0),
      .p_c1     (p_c1),
      .p_c2     (p_c2),
      .na_l_on  (na_l_on),
      .na_l_rgb (na_l_rgb)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   function automatic string test_title(input int id);
      case (id)
         1: return "reset";
         2: return "letters A to Z";
         3: return "invalid codes";
         4: return "box edges";
         5: return "random off-band pixels";
         6: return "streaming";
         default: return "unknown";
      endcase
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected) begin
         $display("mismatch %s: got %h, expected %h at %0t", name, got, expected, $time);
         error_count++;
      end
   endtask

   //////////////////////////////////////////////////
   // Pixel stream
   //////////////////////////////////////////////////

   // Step to the next falling edge and check every pixel due now
   task automatic next_cycle();
      logic exp_on;
      @(negedge clk);
      cycle++;
      while (due_q.size() > 0 && due_q[0] == cycle) begin
         exp_on = exp_q.pop_front();
         void'(due_q.pop_front());
         check_value("na_l_on", 32'(na_l_on), 32'(exp_on));
         check_value("na_l_rgb", 32'(na_l_rgb), exp_on ? 32'h00FF_FF00 : 32'h0);
      end
   endtask

   // Result shows three falling edges after the pixel is driven
   task automatic send_pixel(input logic [pix_w-1:0] x, input logic [pix_w-1:0] y,
                             input logic exp_on);
      next_cycle();
      pix_x = x;
      pix_y = y;
      exp_q.push_back(exp_on);
      due_q.push_back(cycle + 3);
   endtask

   task automatic apply_codes(input logic [23:0] codes);
      next_cycle();
      p_c0 = codes[23:16];
      p_c1 = codes[15:8];
      p_c2 = codes[7:0];
      pix_x = '0;
      pix_y = '0;
      repeat (2) next_cycle();
   endtask

   task automatic end_test(input int id);
      int errs;
      while (due_q.size() > 0) begin
         next_cycle();
         pix_x = '0;
         pix_y = '0;
      end
      errs = error_count - test_errors_start;
      test_count++;
      if (errs > 0) failed_tests++;
      $display("test %0d %s: %s (%0d mismatches)", id, test_title(id),
               (errs == 0) ? "ok" : "FAIL", errs);
      test_errors_start = error_count;
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial begin
      int               id;
      int               cur_test;
      logic [pix_w-1:0] x;
      logic [pix_w-1:0] y;
      void'($urandom(32'hdefff8d7));
      rst_n = 1'b0;
      pix_x = '0;
      pix_y = '0;
      p_c0 = '0;
      p_c1 = '0;
      p_c2 = '0;
      foreach (vectors[i]) vectors[i] = '1;
      $readmemh("testbench/name_stimulus.txt", vectors);
      while (num_vec < max_vectors && vectors[num_vec][55:52] != 4'hF) num_vec++;
      limits_known = 1'b1;
      if (num_vec == 0) begin
         $display("no stimulus vectors could be read from testbench/name_stimulus.txt");
         error_count++;
      end

      // Outputs stay cleared while reset is held and just after
      repeat (5) begin
         @(negedge clk);
         check_value("na_l_on", 32'(na_l_on), 32'h0);
         check_value("na_l_rgb", 32'(na_l_rgb), 32'h0);
      end
      rst_n = 1'b1;
      repeat (3) send_pixel('0, '0, 1'b0);
      end_test(1);

      cur_test = 0;
      for (int i = 0; i < num_vec; i++) begin
         id = int'(vectors[i][55:52]);
         if (id != cur_test && cur_test != 0) end_test(cur_test);
         cur_test = id;
         if (vectors[i][51:28] != {p_c0, p_c1, p_c2}) apply_codes(vectors[i][51:28]);
         send_pixel(vectors[i][27:16], vectors[i][15:4], vectors[i][0]);
      end
      if (cur_test != 0) end_test(cur_test);

      // Any row outside 170 to 181 is off whatever the letters are
      repeat (rand_count) begin
         x = pix_w'($urandom);
         y = pix_w'($urandom);
         while (y >= pix_w'(170) && y <= pix_w'(181)) y = pix_w'($urandom);
         send_pixel(x, y, 1'b0);
      end
      end_test(5);

      $display("%0d tests run, %0d failed, %0d mismatches", test_count, failed_tests,
               error_count);
      if (error_count == 0 && failed_tests == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

   // Watchdog
   initial begin
      longint timeout_ns;
      wait (limits_known);
      timeout_ns = longint'(num_vec + rand_count + margin_cycles) * clk_period;
      #(timeout_ns);
      $display("run timed out after %0d ns without finishing", timeout_ns);
      $display("tests failed");
      $finish;
   end

endmodule

// ==== testbench/name_stimulus.txt ====
// test _ code0 _ code1 _ code2 _ pix_x _ pix_y _ expected na_l_on, all in hex
// slots start at columns 12C 14A 168, letters cover rows 0AA to 0B5
2_41_42_43_12D_0AB_0
2_41_42_43_14B_0AB_1
2_44_45_46_12E_0AA_0
2_44_45_46_14C_0B0_1
2_47_48_49_14B_0B1_0
2_47_48_49_169_0AD_1
2_4A_4B_4C_12C_0B3_0
2_4A_4B_4C_14B_0B0_1
2_4D_4E_4F_12D_0AC_1
2_4D_4E_4F_169_0B0_0
2_50_51_52_12E_0B2_0
2_50_51_52_14C_0B5_1
2_53_54_55_12C_0B2_0
2_53_54_55_14B_0B5_1
2_56_57_58_12C_0B5_0
2_56_57_58_14B_0B2_1
2_59_5A_41_12D_0B2_1
2_59_5A_41_14A_0B0_0
3_61_31_40_12D_0AA_1
3_61_31_40_14A_0AA_0
3_61_31_40_16A_0AB_1
3_5B_FF_7A_12D_0B1_0
3_5B_FF_7A_14B_0B2_1
3_5B_FF_7A_16A_0AC_1
4_4F_4F_4F_12B_0B0_0
4_4F_4F_4F_12C_0AA_1
4_4F_4F_4F_12F_0B0_0
4_4F_4F_4F_12C_0A9_0
4_4F_4F_4F_12C_0B6_0
4_4F_4F_4F_149_0B0_0
4_4F_4F_4F_13B_0B0_0
4_4F_4F_4F_159_0B0_0
4_4F_4F_4F_16A_0B5_1
4_4F_4F_4F_16B_0B0_0
6_4E_41_48_12C_0AA_1
6_4E_41_48_12E_0AA_0
6_4E_41_48_14B_0AA_1
6_4E_41_48_169_0AA_0
6_4E_41_48_168_0AA_1
6_4E_41_48_000_000_0
6_4E_41_48_14B_0AB_0
6_4E_41_48_16A_0B5_1
6_4E_41_48_12D_0AB_0
6_4E_41_48_12E_0AB_1

// ==== tb.f ====
design/name_pkg.sv
design/glyph_rom.sv
design/char_decode.sv
design/letter_slot.sv
design/overlay_mixer.sv
design/gameover_name.sv
testbench/tb_gameover_name.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_gameover_name
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
STIMULUS  ?= testbench/name_stimulus.txt

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only when the testbench prints its pass line
run: $(SIM) $(STIMULUS)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'all tests passed'

clean:
	rm -rf $(BUILD_DIR)
